//--- files.f
source/vctrl_pkg.sv
source/vcsr_file.sv
source/req_buffer.sv
source/issue_ctrl.sv
source/vector_controller.sv
tests/tb_vector_controller.sv

//--- Makefile
# Verilator build and run for the vector issue controller

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_vector_controller
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_vector_controller.sv
// Testbench for the vector controller with CSR reference model, stimulus tasks and assertions
`timescale 1ns/1ps

module tb_vector_controller;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  logic                   issue_valid_i;
  logic                   issue_ready_o;
  vctrl_pkg::vreq_t       issue_req_i;
  vctrl_pkg::issue_resp_t issue_resp_o;
  logic                   result_valid_o;
  logic                   result_ready_i;
  vctrl_pkg::result_t     result_o;
  logic                   unit_req_valid_o;
  vctrl_pkg::vreq_t       unit_req_o;
  vctrl_pkg::unit_ready_t unit_ready_i;

  // Reference CSR state and the single expected output
  vctrl_pkg::vtype_t      m_vtype;
  vctrl_pkg::vlen_t       m_vl;
  vctrl_pkg::vlen_t       m_vstart;
  logic                   exp_pending;
  logic                   exp_to_unit;
  vctrl_pkg::result_t     exp_result;
  vctrl_pkg::vreq_t       exp_unit_req;
  vctrl_pkg::issue_resp_t exp_resp;
  integer                 seed = 32'hf606af8b;
  int                     cycles;
  logic [vctrl_pkg::ID_W-1:0] next_id;

  vector_controller i_vector_controller (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("Test failed");
      $fatal(1, "Timeout after %0d cycles", cycles);
    end
  end

  task automatic stop_value(input string name, input logic [127:0] got, input logic [127:0] exp);
    $display("** Error %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("Test failed");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic stop_text(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "Unexpected behavior");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_result_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o |-> exp_pending && !exp_to_unit)
    else stop_text("Result appeared with no controller request outstanding");
  a_result_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o |-> result_o == exp_result)
    else stop_value("result_o", 128'($sampled(result_o)), 128'(exp_result));
  a_unit_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unit_req_valid_o |-> exp_pending && exp_to_unit)
    else stop_text("Unit request appeared with no unit request outstanding");
  a_unit_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unit_req_valid_o |-> unit_req_o == exp_unit_req)
    else stop_value("unit_req_o", 128'($sampled(unit_req_o)), 128'(exp_unit_req));
  a_resp_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i |-> issue_resp_o == exp_resp)
    else stop_value("issue_resp_o", 128'($sampled(issue_resp_o)), 128'(exp_resp));
  a_wait_blocks: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (issue_valid_i && issue_resp_o.accept && !result_valid_o && !unit_req_valid_o)
      |=> !issue_ready_o)
    else stop_text("issue_ready_o high while a request waits");
  a_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !issue_ready_o |-> exp_pending)
    else stop_text("issue_ready_o low with nothing outstanding");

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // LMUL in eighths keeps fractional settings integer
  function automatic int lmul_eighths(input vctrl_pkg::vtype_t vt);
    case (vt.vlmul)
      vctrl_pkg::LMUL_F8: return 1;
      vctrl_pkg::LMUL_F4: return 2;
      vctrl_pkg::LMUL_F2: return 4;
      vctrl_pkg::LMUL_2:  return 16;
      vctrl_pkg::LMUL_4:  return 32;
      vctrl_pkg::LMUL_8:  return 64;
      default:            return 8;
    endcase
  endfunction

  function automatic int vlmax_of(input vctrl_pkg::vtype_t vt);
    int sew_bytes;
    sew_bytes = 1 << vt.vsew;
    return (int'(vctrl_pkg::VLENB) / sew_bytes) * lmul_eighths(vt) / 8;
  endfunction

  function automatic bit cfg_legal(input vctrl_pkg::vtype_t vt, input bit keep);
    int sew_bits;
    int cur_bits;
    sew_bits = 8 << vt.vsew;
    cur_bits = 8 << m_vtype.vsew;
    if (vt.vsew == vctrl_pkg::EW_64) return 1'b0;
    if (vt.vlmul == vctrl_pkg::LMUL_RES || vt.vlmul == vctrl_pkg::LMUL_F8) return 1'b0;
    if (vt.vlmul == vctrl_pkg::LMUL_F2 && sew_bits * 2 > int'(vctrl_pkg::ELEN)) return 1'b0;
    if (vt.vlmul == vctrl_pkg::LMUL_F4 && sew_bits * 4 > int'(vctrl_pkg::ELEN)) return 1'b0;
    if (keep && (sew_bits * 64 / lmul_eighths(vt) != cur_bits * 64 / lmul_eighths(m_vtype)))
      return 1'b0;
    return 1'b1;
  endfunction

  function automatic logic [31:0] csr_value(input logic [11:0] addr);
    case (addr)
      vctrl_pkg::CSR_VSTART: return 32'(m_vstart);
      vctrl_pkg::CSR_VL:     return 32'(m_vl);
      vctrl_pkg::CSR_VTYPE:  return 32'(m_vtype);
      vctrl_pkg::CSR_VLENB:  return 32'd32;
      default:               return 32'd0;
    endcase
  endfunction

  // Sets the expectation for r and then advances the model
  task automatic predict(input vctrl_pkg::vreq_t r);
    vctrl_pkg::vlen_t vs_old;
    int               vmax;
    vs_old = m_vstart;
    exp_resp.accept = !r.illegal && !(r.ex_unit != vctrl_pkg::CON && m_vtype.vill);
    exp_resp.writeback = r.ex_unit == vctrl_pkg::CON && r.use_rd;
    exp_resp.loadstore = r.ex_unit == vctrl_pkg::LSU;
    exp_to_unit = r.ex_unit != vctrl_pkg::CON;
    exp_result = '{id: r.id, rd: r.rd, data: 32'd0, we: 1'b1};
    exp_unit_req = r;
    exp_unit_req.vl = m_vl;
    exp_unit_req.vstart = m_vstart;
    if (r.ex_unit != vctrl_pkg::LSU) exp_unit_req.vtype = m_vtype;
    if (!exp_resp.accept) return;
    if (r.op == vctrl_pkg::VCSR && r.use_rd) exp_result.data = csr_value(r.csr_addr);
    if (r.reset_vstart) m_vstart = '0;
    if (r.op == vctrl_pkg::VCSR && r.csr_addr == vctrl_pkg::CSR_VSTART) begin
      case (r.csr_cmd)
        vctrl_pkg::CSR_WRITE: m_vstart = vctrl_pkg::vlen_t'(r.rs1);
        vctrl_pkg::CSR_SET:   m_vstart = vs_old | vctrl_pkg::vlen_t'(r.rs1);
        vctrl_pkg::CSR_CLEAR: m_vstart = vs_old & ~vctrl_pkg::vlen_t'(r.rs1);
        default:              m_vstart = m_vstart;
      endcase
    end
    if (r.op == vctrl_pkg::VCFG) begin
      if (!cfg_legal(r.vtype, r.keep_vl)) begin
        m_vtype = vctrl_pkg::VTYPE_RESET;
        m_vl    = '0;
      end else begin
        vmax = vlmax_of(r.vtype);
        m_vtype = r.vtype;
        m_vtype.vill = 1'b0;
        if (!r.keep_vl) begin
          m_vl = (r.rs1 == 32'hffff_ffff || r.rs1 > 32'(vmax)) ? vctrl_pkg::vlen_t'(vmax)
                                                                : vctrl_pkg::vlen_t'(r.rs1);
        end
      end
      exp_result.data = 32'(m_vl);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic shuffle_ready();
    unit_ready_i   = vctrl_pkg::unit_ready_t'($random(seed));
    result_ready_i = 1'($random(seed));
  endtask

  // Entered and left on a falling edge with one request in flight
  task automatic send(input vctrl_pkg::vreq_t r);
    logic fired;
    r.id = next_id;
    next_id = next_id + 1'b1;
    predict(r);
    issue_req_i   = r;
    issue_valid_i = 1'b1;
    exp_pending   = exp_resp.accept;
    shuffle_ready();
    forever begin
      #1;
      fired = result_valid_o || unit_req_valid_o;
      @(posedge clk_i);
      @(negedge clk_i);
      issue_valid_i = 1'b0;
      if (fired || !exp_resp.accept) break;
      shuffle_ready();
    end
    exp_pending = 1'b0;
  endtask

  function automatic vctrl_pkg::vreq_t base_req(input vctrl_pkg::vop_e op,
                                                input vctrl_pkg::ex_unit_e unit);
    vctrl_pkg::vreq_t r;
    r = '0;
    r.op = op;
    r.ex_unit = unit;
    r.rd = 5'(next_id) + 5'd1;
    r.use_rd = 1'b1;
    return r;
  endfunction

  task automatic cfg(input int sew, input int lmul, input logic [31:0] avl, input bit keep);
    vctrl_pkg::vreq_t r;
    r = base_req(vctrl_pkg::VCFG, vctrl_pkg::CON);
    r.vtype.vsew  = vctrl_pkg::vsew_e'(sew);
    r.vtype.vlmul = vctrl_pkg::vlmul_e'(lmul);
    r.vtype.vta   = 1'($random(seed));
    r.rs1 = avl;
    r.keep_vl = keep;
    send(r);
  endtask

  task automatic csr_op(input logic [11:0] addr, input vctrl_pkg::csr_cmd_e cmd,
                        input logic [31:0] val);
    vctrl_pkg::vreq_t r;
    r = base_req(vctrl_pkg::VCSR, vctrl_pkg::CON);
    r.csr_addr = addr;
    r.csr_cmd = cmd;
    r.rs1 = val;
    send(r);
  endtask

  task automatic exec(input vctrl_pkg::ex_unit_e unit, input bit rst_vs, input bit bad);
    vctrl_pkg::vreq_t r;
    r = base_req(vctrl_pkg::VEXEC, unit);
    r.use_rd = 1'b0;
    r.reset_vstart = rst_vs;
    r.illegal = bad;
    r.vtype = '{vill: 1'b0, vma: 1'b1, vta: 1'b0, vsew: vctrl_pkg::EW_16, vlmul: vctrl_pkg::LMUL_2};
    send(r);
  endtask

  initial begin
    logic [31:0] rnd;
    rst_n_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i = '0;
    result_ready_i = 1'b0;
    unit_ready_i = '0;
    exp_pending = 1'b0;
    exp_to_unit = 1'b0;
    exp_result = '0;
    exp_unit_req = '0;
    exp_resp = '0;
    cycles = 0;
    next_id = '0;
    m_vtype = vctrl_pkg::VTYPE_RESET;
    m_vl = '0;
    m_vstart = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset state and vill rejection
    csr_op(vctrl_pkg::CSR_VTYPE, vctrl_pkg::CSR_NONE, 32'd0);
    csr_op(vctrl_pkg::CSR_VL, vctrl_pkg::CSR_NONE, 32'd0);
    exec(vctrl_pkg::VFU, 1'b0, 1'b0);

    // Random configurations with read-back
    repeat (30) begin
      rnd = $random(seed);
      cfg(int'(rnd[5:4]) % 3, int'(rnd[10:8]), (rnd[3:0] == 4'd0) ? 32'hffff_ffff
          : {23'd0, rnd[24:16]}, 1'b0);
      csr_op(vctrl_pkg::CSR_VL, vctrl_pkg::CSR_NONE, 32'd0);
    end

    // Illegal settings
    cfg(3, 0, 32'd10, 1'b0);
    cfg(0, 4, 32'd10, 1'b0);
    cfg(0, 5, 32'd10, 1'b0);
    cfg(2, 7, 32'd10, 1'b0);
    csr_op(vctrl_pkg::CSR_VTYPE, vctrl_pkg::CSR_NONE, 32'd0);
    cfg(0, 0, 32'd20, 1'b0);
    cfg(1, 0, 32'd0, 1'b1);
    csr_op(vctrl_pkg::CSR_VTYPE, vctrl_pkg::CSR_NONE, 32'd0);
    cfg(1, 1, 32'd0, 1'b0);
    cfg(0, 7, 32'd0, 1'b1);

    // vstart commands and CSR stamping
    cfg(1, 1, 32'hffff_ffff, 1'b0);
    csr_op(vctrl_pkg::CSR_VSTART, vctrl_pkg::CSR_WRITE, 32'h0f3);
    csr_op(vctrl_pkg::CSR_VSTART, vctrl_pkg::CSR_SET, 32'h10c);
    csr_op(vctrl_pkg::CSR_VSTART, vctrl_pkg::CSR_CLEAR, 32'h0a5);
    exec(vctrl_pkg::VFU, 1'b0, 1'b0);
    exec(vctrl_pkg::SLD, 1'b0, 1'b0);
    exec(vctrl_pkg::LSU, 1'b1, 1'b0);
    csr_op(vctrl_pkg::CSR_VSTART, vctrl_pkg::CSR_NONE, 32'd0);
    csr_op(vctrl_pkg::CSR_VLENB, vctrl_pkg::CSR_NONE, 32'd0);
    csr_op(vctrl_pkg::CSR_VXRM, vctrl_pkg::CSR_NONE, 32'd0);

    // Random mix under random back-pressure
    repeat (60) begin
      rnd = $random(seed);
      case (rnd[2:0])
        3'd0: cfg(int'(rnd[5:4]), int'(rnd[10:8]), {26'd0, rnd[21:16]}, rnd[12]);
        3'd1: csr_op(vctrl_pkg::CSR_VSTART, vctrl_pkg::csr_cmd_e'(rnd[6:5]), {23'd0, rnd[24:16]});
        3'd2: csr_op(vctrl_pkg::CSR_VL, vctrl_pkg::CSR_NONE, 32'd0);
        default: exec(vctrl_pkg::ex_unit_e'(rnd[4:3]), rnd[7], rnd[13:11] == 3'd0);
      endcase
    end

    repeat (3) @(negedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- source/vector_controller.sv
// Vector issue controller top level with CSR file, request buffer and issue logic
`timescale 1ns/1ps

module vector_controller (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Core issue
  input  logic                   issue_valid_i,
  output logic                   issue_ready_o,
  input  vctrl_pkg::vreq_t       issue_req_i,
  output vctrl_pkg::issue_resp_t issue_resp_o,
  // Core result
  output logic                   result_valid_o,
  input  logic                   result_ready_i,
  output vctrl_pkg::result_t     result_o,
  // Execution units
  output logic                   unit_req_valid_o,
  output vctrl_pkg::vreq_t       unit_req_o,
  input  vctrl_pkg::unit_ready_t unit_ready_i
);

  vctrl_pkg::vtype_t cur_vtype;
  vctrl_pkg::vlen_t  cur_vl;
  vctrl_pkg::vlen_t  cur_vstart;
  vctrl_pkg::vlen_t  new_vl;
  logic [31:0]       csr_rdata;
  logic              push_valid;
  logic              head_valid;
  vctrl_pkg::vreq_t  head;
  logic              pop;

  vcsr_file i_vcsr_file (
    .clk_i      (clk_i     ),
    .rst_n_i    (rst_n_i   ),
    .pop_i      (pop       ),
    .req_i      (head      ),
    .vtype_o    (cur_vtype ),
    .vl_o       (cur_vl    ),
    .vstart_o   (cur_vstart),
    .new_vl_o   (new_vl    ),
    .csr_rdata_o(csr_rdata )
  );

  req_buffer i_req_buffer (
    .clk_i       (clk_i        ),
    .rst_n_i     (rst_n_i      ),
    .push_valid_i(push_valid   ),
    .push_ready_o(issue_ready_o),
    .push_data_i (issue_req_i  ),
    .pop_valid_o (head_valid   ),
    .pop_ready_i (pop          ),
    .pop_data_o  (head         )
  );

  issue_ctrl i_issue_ctrl (
    .issue_valid_i   (issue_valid_i   ),
    .issue_req_i     (issue_req_i     ),
    .cur_vtype_i     (cur_vtype       ),
    .cur_vl_i        (cur_vl          ),
    .cur_vstart_i    (cur_vstart      ),
    .new_vl_i        (new_vl          ),
    .csr_rdata_i     (csr_rdata       ),
    .head_valid_i    (head_valid      ),
    .head_i          (head            ),
    .unit_ready_i    (unit_ready_i    ),
    .result_ready_i  (result_ready_i  ),
    .issue_resp_o    (issue_resp_o    ),
    .push_valid_o    (push_valid      ),
    .pop_o           (pop             ),
    .unit_req_valid_o(unit_req_valid_o),
    .unit_req_o      (unit_req_o      ),
    .result_valid_o  (result_valid_o  ),
    .result_o        (result_o        )
  );

endmodule

//--- source/issue_ctrl.sv
// Issue decision, unit stall and pop, CSR stamping, result retirement and checks
`timescale 1ns/1ps

module issue_ctrl (
  input  logic                   issue_valid_i,
  input  vctrl_pkg::vreq_t       issue_req_i,
  input  vctrl_pkg::vtype_t      cur_vtype_i,
  input  vctrl_pkg::vlen_t       cur_vl_i,
  input  vctrl_pkg::vlen_t       cur_vstart_i,
  input  vctrl_pkg::vlen_t       new_vl_i,
  input  logic [31:0]            csr_rdata_i,
  input  logic                   head_valid_i,
  input  vctrl_pkg::vreq_t       head_i,
  input  vctrl_pkg::unit_ready_t unit_ready_i,
  input  logic                   result_ready_i,
  output vctrl_pkg::issue_resp_t issue_resp_o,
  output logic                   push_valid_o,
  output logic                   pop_o,
  output logic                   unit_req_valid_o,
  output vctrl_pkg::vreq_t       unit_req_o,
  output logic                   result_valid_o,
  output vctrl_pkg::result_t     result_o
);

  logic head_stall;
  logic head_is_con;

  ////////////////////////////////////////////////////////////////////////////
  // Accept
  ////////////////////////////////////////////////////////////////////////////

  // Vector work needs a valid vtype, config and CSR ops do not
  always_comb begin : proc_resp
    issue_resp_o.accept    = !issue_req_i.illegal
                          && !(issue_req_i.ex_unit != vctrl_pkg::CON && cur_vtype_i.vill);
    issue_resp_o.writeback = (issue_req_i.ex_unit == vctrl_pkg::CON) && issue_req_i.use_rd;
    issue_resp_o.loadstore = issue_req_i.ex_unit == vctrl_pkg::LSU;
  end

  assign push_valid_o = issue_valid_i && issue_resp_o.accept;

  ////////////////////////////////////////////////////////////////////////////
  // Stall and pop
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : proc_stall
    unique case (head_i.ex_unit)
      vctrl_pkg::CON: head_stall = !result_ready_i;
      vctrl_pkg::VFU: head_stall = !unit_ready_i.vfu;
      vctrl_pkg::LSU: head_stall = !unit_ready_i.vlsu;
      default:        head_stall = !unit_ready_i.vsldu;
    endcase
  end

  assign head_is_con      = head_i.ex_unit == vctrl_pkg::CON;
  assign pop_o            = head_valid_i && !head_stall;
  assign unit_req_valid_o = pop_o && !head_is_con;
  assign result_valid_o   = pop_o && head_is_con;

  // Units see the CSRs as they are before this instruction retires
  always_comb begin : proc_stamp
    unit_req_o = head_i;
    if (!head_is_con) begin
      unit_req_o.vl     = cur_vl_i;
      unit_req_o.vstart = cur_vstart_i;
      // Loads and stores carry their own element width
      if (head_i.ex_unit != vctrl_pkg::LSU) begin
        unit_req_o.vtype = cur_vtype_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Retire
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : proc_result
    result_o    = '0;
    result_o.id = head_i.id;
    result_o.rd = head_i.rd;
    result_o.we = 1'b1;
    if (head_i.op == vctrl_pkg::VCFG) begin
      result_o.data = {{(32 - vctrl_pkg::VL_W){1'b0}}, new_vl_i};
    end else if (head_i.op == vctrl_pkg::VCSR && head_i.use_rd) begin
      // Old CSR value, the update lands next cycle
      result_o.data = csr_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : proc_checks
    if (unit_req_valid_o) begin
      a_no_con_to_unit: assert final (unit_req_o.ex_unit != vctrl_pkg::CON)
        else $error("controller-executed request sent to a unit");
    end
    a_one_outlet: assert final (!(result_valid_o && unit_req_valid_o))
      else $error("result and unit request in the same cycle");
  end

endmodule

//--- source/req_buffer.sv
// One-entry fall-through request buffer between the core and the issue logic
`timescale 1ns/1ps

module req_buffer (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_valid_i,
  output logic             push_ready_o,
  input  vctrl_pkg::vreq_t push_data_i,
  output logic             pop_valid_o,
  input  logic             pop_ready_i,
  output vctrl_pkg::vreq_t pop_data_o
);

  logic             full_q;
  vctrl_pkg::vreq_t data_q;
  logic             store;

  // Empty buffer passes the request straight through
  assign push_ready_o = !full_q;
  assign pop_valid_o  = full_q || push_valid_i;
  assign pop_data_o   = full_q ? data_q : push_data_i;

  // Keep it only if it could not leave right away
  assign store = push_valid_i && push_ready_o && !pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (store) begin
      full_q <= 1'b1;
    end else if (full_q && pop_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      data_q <= push_data_i;
    end
  end

  // The core only pushes while the entry is free
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_valid_i |-> push_ready_o)
    else $error("push while the buffer is full");

endmodule

//--- source/vcsr_file.sv
// Vector CSR registers with vtype legality, vlmax and vl computation and CSR read mux
`timescale 1ns/1ps

module vcsr_file (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               pop_i,
  input  vctrl_pkg::vreq_t   req_i,
  output vctrl_pkg::vtype_t  vtype_o,
  output vctrl_pkg::vlen_t   vl_o,
  output vctrl_pkg::vlen_t   vstart_o,
  output vctrl_pkg::vlen_t   new_vl_o,
  output logic [31:0]        csr_rdata_o
);

  vctrl_pkg::vlen_t  vstart_q, vstart_d;
  vctrl_pkg::vlen_t  vl_q, vl_d;
  vctrl_pkg::vtype_t vtype_q, vtype_d;

  vctrl_pkg::vlen_t  vlmax_base;
  vctrl_pkg::vlen_t  vlmax;
  vctrl_pkg::vlen_t  avl_vl;
  logic [31:0]       sew_bits;
  logic              frac_bad;
  logic              ratio_change;
  logic              cfg_illegal;
  logic signed [4:0] ratio_req;
  logic signed [4:0] ratio_cur;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration legality
  ////////////////////////////////////////////////////////////////////////////

  // Fractional LMUL 1/f needs SEW <= ELEN/f
  assign sew_bits = 32'd8 << req_i.vtype.vsew;

  always_comb begin : proc_frac
    unique case (req_i.vtype.vlmul)
      vctrl_pkg::LMUL_F2: frac_bad = sew_bits > (vctrl_pkg::ELEN / 2);
      vctrl_pkg::LMUL_F4: frac_bad = sew_bits > (vctrl_pkg::ELEN / 4);
      default:            frac_bad = 1'b0;
    endcase
  end

  // log2(SEW/8) - log2(LMUL), the vlmul encoding is already signed log2
  assign ratio_req = $signed({3'b000, req_i.vtype.vsew})
                   - $signed({{2{req_i.vtype.vlmul[2]}}, req_i.vtype.vlmul});
  assign ratio_cur = $signed({3'b000, vtype_q.vsew})
                   - $signed({{2{vtype_q.vlmul[2]}}, vtype_q.vlmul});

  assign ratio_change = req_i.keep_vl && (ratio_req != ratio_cur);

  assign cfg_illegal = (req_i.vtype.vsew > vctrl_pkg::EW_32)
                    || (req_i.vtype.vlmul == vctrl_pkg::LMUL_RES)
                    || (req_i.vtype.vlmul == vctrl_pkg::LMUL_F8)
                    || frac_bad
                    || ratio_change;

  ////////////////////////////////////////////////////////////////////////////
  // vlmax and new vl
  ////////////////////////////////////////////////////////////////////////////

  assign vlmax_base = vctrl_pkg::vlen_t'(vctrl_pkg::VLENB) >> req_i.vtype.vsew;

  always_comb begin : proc_vlmax
    unique case (req_i.vtype.vlmul)
      vctrl_pkg::LMUL_F2: vlmax = vlmax_base >> 1;
      vctrl_pkg::LMUL_F4: vlmax = vlmax_base >> 2;
      vctrl_pkg::LMUL_2:  vlmax = vlmax_base << 1;
      vctrl_pkg::LMUL_4:  vlmax = vlmax_base << 2;
      vctrl_pkg::LMUL_8:  vlmax = vlmax_base << 3;
      default:            vlmax = vlmax_base;
    endcase
  end

  // All ones in rs1 requests vlmax
  assign avl_vl = (req_i.rs1 == '1) ? vlmax :
                  ({{(32 - vctrl_pkg::VL_W){1'b0}}, vlmax} < req_i.rs1) ? vlmax :
                  vctrl_pkg::vlen_t'(req_i.rs1);

  // Next CSR state if the head pops this cycle
  always_comb begin : proc_next
    vstart_d = vstart_q;
    vl_d     = vl_q;
    vtype_d  = vtype_q;

    if (req_i.reset_vstart) begin
      vstart_d = '0;
    end

    if (req_i.op == vctrl_pkg::VCSR && req_i.csr_addr == vctrl_pkg::CSR_VSTART) begin
      unique case (req_i.csr_cmd)
        vctrl_pkg::CSR_WRITE: vstart_d = vctrl_pkg::vlen_t'(req_i.rs1);
        vctrl_pkg::CSR_SET:   vstart_d = vstart_q | vctrl_pkg::vlen_t'(req_i.rs1);
        vctrl_pkg::CSR_CLEAR: vstart_d = vstart_q & ~vctrl_pkg::vlen_t'(req_i.rs1);
        default:              vstart_d = vstart_d;
      endcase
    end

    if (req_i.op == vctrl_pkg::VCFG) begin
      if (cfg_illegal) begin
        vtype_d = vctrl_pkg::VTYPE_RESET;
        vl_d    = '0;
      end else begin
        vtype_d      = req_i.vtype;
        vtype_d.vill = 1'b0;
        if (!req_i.keep_vl) begin
          vl_d = avl_vl;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vtype_q  <= vctrl_pkg::VTYPE_RESET;
    end else if (pop_i) begin
      vstart_q <= vstart_d;
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // CSR read
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : proc_rdata
    unique case (req_i.csr_addr)
      vctrl_pkg::CSR_VSTART: csr_rdata_o = {{(32 - vctrl_pkg::VL_W){1'b0}}, vstart_q};
      vctrl_pkg::CSR_VL:     csr_rdata_o = {{(32 - vctrl_pkg::VL_W){1'b0}}, vl_q};
      vctrl_pkg::CSR_VTYPE:  csr_rdata_o = {{(32 - $bits(vctrl_pkg::vtype_t)){1'b0}}, vtype_q};
      vctrl_pkg::CSR_VLENB:  csr_rdata_o = 32'(vctrl_pkg::VLENB);
      // Fixed-point state is not implemented
      vctrl_pkg::CSR_VXSAT,
      vctrl_pkg::CSR_VXRM,
      vctrl_pkg::CSR_VCSR:   csr_rdata_o = '0;
      default:               csr_rdata_o = '0;
    endcase
  end

  assign vtype_o  = vtype_q;
  assign vl_o     = vl_q;
  assign vstart_o = vstart_q;
  assign new_vl_o = vl_d;

  a_vill_clears_vl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vtype_q.vill |-> (vl_q == '0))
    else $error("vill set with nonzero vl %0h", vl_q);

endmodule

//--- source/vctrl_pkg.sv
// Vector controller constants, CSR addresses, enums and packed request/response structs
package vctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Machine parameters
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned VLEN  = 256;
  localparam int unsigned VLENB = VLEN / 8;
  localparam int unsigned ELEN  = 32;
  localparam int unsigned MAXVL = VLEN;
  localparam int unsigned VL_W  = $clog2(MAXVL + 1);
  localparam int unsigned ID_W  = 4;

  // Standard vector CSR addresses
  localparam logic [11:0] CSR_VSTART = 12'h008;
  localparam logic [11:0] CSR_VXSAT  = 12'h009;
  localparam logic [11:0] CSR_VXRM   = 12'h00A;
  localparam logic [11:0] CSR_VCSR   = 12'h00F;
  localparam logic [11:0] CSR_VL     = 12'hC20;
  localparam logic [11:0] CSR_VTYPE  = 12'hC21;
  localparam logic [11:0] CSR_VLENB  = 12'hC22;

  ////////////////////////////////////////////////////////////////////////////
  // Vector configuration types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [VL_W-1:0] vlen_t;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2,
    EW_64 = 2'd3
  } vsew_e;

  // Fractional settings use the top half, read as signed log2 of LMUL
  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    logic   vma;
    logic   vta;
    vsew_e  vsew;
    vlmul_e vlmul;
  } vtype_t;

  localparam vtype_t VTYPE_RESET = '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: EW_8, vlmul: LMUL_1};

  ////////////////////////////////////////////////////////////////////////////
  // Instruction and handshake payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {CON, VFU, LSU, SLD} ex_unit_e;

  typedef enum logic [1:0] {VCFG, VCSR, VEXEC} vop_e;

  // Only vstart is writable through these commands
  typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_cmd_e;

  typedef struct packed {
    logic [ID_W-1:0] id;
    vop_e            op;
    ex_unit_e        ex_unit;
    logic            illegal;
    logic [31:0]     rs1;
    logic [4:0]      rd;
    logic            use_rd;
    logic [11:0]     csr_addr;
    csr_cmd_e        csr_cmd;
    vtype_t          vtype;
    logic            keep_vl;
    logic            reset_vstart;
    vlen_t           vl;
    vlen_t           vstart;
  } vreq_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } issue_resp_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [4:0]      rd;
    logic [31:0]     data;
    logic            we;
  } result_t;

  typedef struct packed {
    logic vfu;
    logic vlsu;
    logic vsldu;
  } unit_ready_t;

endpackage
